// File: source/lpif_link_consts.svh
// Link widths and PHY layout
`ifndef LPIF_LINK_CONSTS_SVH
`define LPIF_LINK_CONSTS_SVH

//////////////////////////////
// Channel fields
//////////////////////////////

// Channel data bus
`define LPIF_DATA_W 32
// Opaque CRC carried with the data
`define LPIF_CRC_W 8

//////////////////////////////
// PHY word layout
//////////////////////////////

// One PHY channel word, marker on top, then strobe
`define LPIF_PHY_W 40
// What is left after marker and strobe
`define LPIF_PHY_PAYLOAD_W (`LPIF_PHY_W - 2)

// Online delay counts and debug counters
`define LPIF_DELAY_W 16
`define LPIF_DBG_W 32

`endif

// File: source/lpif_link_pkg.sv
// Link channel and PHY types
`default_nettype none
`include "lpif_link_consts.svh"

package lpif_link_pkg;

  //////////////////////////////
  // Channel word
  //////////////////////////////

  // Same layout upstream, downstream and on the flit
  // valid sits in bit 0
  typedef struct packed {
    logic [3:0]             state;
    logic [1:0]             protid;
    logic [`LPIF_DATA_W-1:0] data;
    logic                   dvalid;
    logic [`LPIF_CRC_W-1:0] crc;
    logic                   crc_valid;
    logic                   valid;
  } lpif_chan_t;

  // Flit size, and the part that spills into PHY word 1
  localparam int LPIF_FLIT_W      = $bits(lpif_chan_t);
  localparam int LPIF_PHY1_FLIT_W = LPIF_FLIT_W - `LPIF_PHY_PAYLOAD_W;

  //////////////////////////////
  // PHY word
  //////////////////////////////

  typedef struct packed {
    logic                          marker;
    logic                          strobe;
    logic [`LPIF_PHY_PAYLOAD_W-1:0] payload;
  } phy_word_t;

  // Next value of an online counter, saturating, cleared when offline
  function automatic logic [`LPIF_DELAY_W-1:0] sync_count(
    input logic                     online,
    input logic [`LPIF_DELAY_W-1:0] cnt
  );
    if (!online) return '0;
    if (&cnt) return cnt;
    return cnt + 1'b1;
  endfunction

  // High once this sample completes the programmed run of online cycles
  function automatic logic sync_done(
    input logic                     online,
    input logic [`LPIF_DELAY_W-1:0] cnt,
    input logic [`LPIF_DELAY_W-1:0] delay
  );
    logic [`LPIF_DELAY_W:0] seen;
    seen = {1'b0, cnt} + 1'b1;
    return online && (seen >= {1'b0, delay});
  endfunction

endpackage

`default_nettype wire

// File: source/lpif_auto_sync.sv
// Online delay and user bit sync
`default_nettype none
`include "lpif_link_consts.svh"

module lpif_auto_sync import lpif_link_pkg::*; (
  input  logic                     clk_wr,
  input  logic                     arst_n,
  // Raw online indications
  input  logic                     tx_online,
  input  logic                     rx_online,
  // Programmed delays, x for rx and y for tx
  input  logic [`LPIF_DELAY_W-1:0] delay_x_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_y_value,
  // User strobe and marker requests
  input  logic                     tx_stb_userbit,
  input  logic [1:0]               tx_mrk_userbit,
  // Delayed online
  output logic                     tx_online_delay,
  output logic                     rx_online_delay,
  // Persistent strobe and marker toward the PHY
  output logic                     tx_auto_stb_userbit,
  output logic [1:0]               tx_auto_mrk_userbit
);

  //////////////////////////////
  // Online counters
  //////////////////////////////

  // Cycles seen with online high, per direction
  logic [`LPIF_DELAY_W-1:0] tx_cnt;
  logic [`LPIF_DELAY_W-1:0] rx_cnt;

  // Delayed online for the coming cycle
  logic tx_up;
  logic rx_up;

  assign tx_up = sync_done(tx_online, tx_cnt, delay_y_value);
  assign rx_up = sync_done(rx_online, rx_cnt, delay_x_value);

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_cnt          <= '0;
      rx_cnt          <= '0;
      tx_online_delay <= 1'b0;
      rx_online_delay <= 1'b0;
    end else begin
      // A drop of online clears the count at once
      tx_cnt          <= sync_count(tx_online, tx_cnt);
      rx_cnt          <= sync_count(rx_online, rx_cnt);
      tx_online_delay <= tx_up;
      rx_online_delay <= rx_up;
    end
  end

  //////////////////////////////
  // User bits
  //////////////////////////////

  // Registered with the same gate as tx_online_delay,
  // so both drop together
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_auto_stb_userbit <= 1'b0;
      tx_auto_mrk_userbit <= '0;
    end else if (tx_up) begin
      tx_auto_stb_userbit <= tx_stb_userbit;
      tx_auto_mrk_userbit <= tx_mrk_userbit;
    end else begin
      tx_auto_stb_userbit <= 1'b0;
      tx_auto_mrk_userbit <= '0;
    end
  end

endmodule

`default_nettype wire

// File: source/lpif_flit_map.sv
// User channel to flit mapping
`default_nettype none
`include "lpif_link_consts.svh"

module lpif_flit_map import lpif_link_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   arst_n,
  // User side
  input  lpif_chan_t             ustrm,
  output lpif_chan_t             dstrm,
  // Link side
  output lpif_chan_t             tx_flit,
  input  lpif_chan_t             rx_flit,
  // Word counters
  output logic [`LPIF_DBG_W-1:0] tx_upstream_debug_status,
  output logic [`LPIF_DBG_W-1:0] rx_downstream_debug_status
);

  //////////////////////////////
  // Upstream
  //////////////////////////////

  // Valid-only channel, no ready
  // Every cycle is taken as it comes
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_flit <= '0;
    end else begin
      tx_flit <= ustrm;
    end
  end

  // Upstream words with valid set, wraps
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_upstream_debug_status <= '0;
    end else if (ustrm.valid) begin
      tx_upstream_debug_status <= tx_upstream_debug_status + 1'b1;
    end
  end

  //////////////////////////////
  // Downstream
  //////////////////////////////

  // rx_flit arrives already qualified
  // A rejected flit comes in as all zero
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      dstrm <= '0;
    end else begin
      dstrm <= rx_flit;
    end
  end

  // Counted on the edge that loads dstrm
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_downstream_debug_status <= '0;
    end else if (rx_flit.valid) begin
      rx_downstream_debug_status <= rx_downstream_debug_status + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/lpif_phy_concat.sv
// Flit split over two PHY words
`default_nettype none
`include "lpif_link_consts.svh"

module lpif_phy_concat import lpif_link_pkg::*; (
  input  logic       clk_wr,
  input  logic       arst_n,
  // Flits
  input  lpif_chan_t tx_flit,
  output lpif_chan_t rx_flit,
  // From auto sync
  input  logic       tx_online_delay,
  input  logic       rx_online_delay,
  input  logic       tx_stb_userbit,
  input  logic [1:0] tx_mrk_userbit,
  // PHY channels
  output phy_word_t  tx_phy0,
  output phy_word_t  tx_phy1,
  input  phy_word_t  rx_phy0,
  input  phy_word_t  rx_phy1
);

  //////////////////////////////
  // Transmit
  //////////////////////////////

  // Next words and their registers
  phy_word_t tx_next0;
  phy_word_t tx_next1;
  phy_word_t tx_q0;
  phy_word_t tx_q1;

  always_comb begin
    tx_next0 = '0;
    tx_next1 = '0;
    // Low flit bits fill word 0
    tx_next0.payload = tx_flit[`LPIF_PHY_PAYLOAD_W-1:0];
    // Remaining top bits in word 1, upper payload stays zero
    tx_next1.payload[LPIF_PHY1_FLIT_W-1:0] =
      tx_flit[LPIF_FLIT_W-1:`LPIF_PHY_PAYLOAD_W];
    tx_next0.strobe = tx_stb_userbit;
    tx_next1.strobe = tx_stb_userbit;
    // One marker bit per lane
    tx_next0.marker = tx_mrk_userbit[0];
    tx_next1.marker = tx_mrk_userbit[1];
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_q0 <= '0;
      tx_q1 <= '0;
    end else begin
      tx_q0 <= tx_next0;
      tx_q1 <= tx_next1;
    end
  end

  // Quiet lanes while tx is not online
  assign tx_phy0 = tx_online_delay ? tx_q0 : '0;
  assign tx_phy1 = tx_online_delay ? tx_q1 : '0;

  //////////////////////////////
  // Receive
  //////////////////////////////

  phy_word_t rx_q0;
  phy_word_t rx_q1;
  logic      rx_strobed;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_q0 <= '0;
      rx_q1 <= '0;
    end else begin
      rx_q0 <= rx_phy0;
      rx_q1 <= rx_phy1;
    end
  end

  // Both channels must carry a strobe
  assign rx_strobed = rx_q0.strobe & rx_q1.strobe;

  // Reassemble, or pass zero when not qualified
  always_comb begin
    rx_flit = '0;
    if (rx_online_delay && rx_strobed) begin
      rx_flit = {rx_q1.payload[LPIF_PHY1_FLIT_W-1:0], rx_q0.payload};
    end
  end

endmodule

`default_nettype wire

// File: source/lpif_link_top.sv
// Logic link slave top
`default_nettype none
`include "lpif_link_consts.svh"

module lpif_link_top import lpif_link_pkg::*; (
  input  logic                     clk_wr,
  input  logic                     arst_n,
  // Control
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  logic [`LPIF_DELAY_W-1:0] delay_x_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_y_value,
  input  logic [1:0]               tx_mrk_userbit,
  input  logic                     tx_stb_userbit,
  // User channels
  input  lpif_chan_t               ustrm,
  output lpif_chan_t               dstrm,
  // PHY
  output phy_word_t                tx_phy0,
  output phy_word_t                tx_phy1,
  input  phy_word_t                rx_phy0,
  input  phy_word_t                rx_phy1,
  // Debug counters
  output logic [`LPIF_DBG_W-1:0]   tx_upstream_debug_status,
  output logic [`LPIF_DBG_W-1:0]   rx_downstream_debug_status
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////

  lpif_chan_t tx_flit;
  lpif_chan_t rx_flit;
  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       tx_auto_stb_userbit;
  logic [1:0] tx_auto_mrk_userbit;

  // Online delays and persistent user bits
  lpif_auto_sync u_auto_sync (
    .clk_wr              (clk_wr),
    .arst_n              (arst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  // User side
  lpif_flit_map u_flit_map (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .ustrm                      (ustrm),
    .dstrm                      (dstrm),
    .tx_flit                    (tx_flit),
    .rx_flit                    (rx_flit),
    .tx_upstream_debug_status   (tx_upstream_debug_status),
    .rx_downstream_debug_status (rx_downstream_debug_status)
  );

  // PHY side
  lpif_phy_concat u_phy_concat (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_userbit  (tx_auto_stb_userbit),
    .tx_mrk_userbit  (tx_auto_mrk_userbit),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1)
  );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
// Testbench clock source
`default_nettype none

module tb_clk_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // Starts low, first rising edge at 50 ns
  initial begin
    clk = 1'b0;
  end

  // 100 ns period
  always begin
    #50 clk = ~clk;
  end

endmodule

`default_nettype wire

// File: verif/lpif_link_sva.sv
// PHY concat assertions
`default_nettype none

module lpif_link_sva import lpif_link_pkg::*; (
  input logic       clk_wr,
  input logic       arst_n,
  input logic       tx_online_delay,
  input logic       rx_online_delay,
  input phy_word_t  tx_phy0,
  input phy_word_t  tx_phy1,
  input lpif_chan_t rx_flit
);
  timeunit 1ns;
  timeprecision 100ps;

  // Count of failed properties
  int assert_fails = 0;

  // Both lanes quiet while tx is offline
  tx_quiet_a: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !tx_online_delay |-> ((tx_phy0 == '0) && (tx_phy1 == '0)))
    else begin
      assert_fails++;
      $error("tx PHY word not zero while tx_online_delay is low");
    end

  // No flit accepted before rx is online
  rx_gate_a: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !rx_online_delay |-> !rx_flit.valid)
    else begin
      assert_fails++;
      $error("rx_flit.valid set while rx_online_delay is low");
    end

  // Marker never without strobe, per lane
  mrk0_a: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !tx_phy0.strobe |-> !tx_phy0.marker)
    else begin
      assert_fails++;
      $error("tx_phy0 marker set with strobe clear");
    end

  mrk1_a: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !tx_phy1.strobe |-> !tx_phy1.marker)
    else begin
      assert_fails++;
      $error("tx_phy1 marker set with strobe clear");
    end

endmodule

bind lpif_phy_concat lpif_link_sva u_sva (
  .clk_wr          (clk_wr),
  .arst_n          (arst_n),
  .tx_online_delay (tx_online_delay),
  .rx_online_delay (rx_online_delay),
  .tx_phy0         (tx_phy0),
  .tx_phy1         (tx_phy1),
  .rx_flit         (rx_flit)
);

`default_nettype wire

// File: verif/tb_lpif_link.sv
// Link slave loopback testbench
`default_nettype none
`include "lpif_link_consts.svh"

module tb_lpif_link import lpif_link_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  // One table row, the word and the user bits sent with it
  typedef struct packed {
    lpif_chan_t word;
    logic       stb;
    logic [1:0] mrk;
  } stim_t;

  localparam int NUM_ROWS    = 12;
  localparam int TIMEOUT_CYC = 50;

  logic                     clk_wr;
  logic                     arst_n;
  logic                     tx_online;
  logic                     rx_online;
  logic [`LPIF_DELAY_W-1:0] delay_x_value;
  logic [`LPIF_DELAY_W-1:0] delay_y_value;
  logic [1:0]               tx_mrk_userbit;
  logic                     tx_stb_userbit;
  lpif_chan_t               ustrm;
  lpif_chan_t               dstrm;
  phy_word_t                tx_phy0;
  phy_word_t                tx_phy1;
  logic [`LPIF_DBG_W-1:0]   tx_dbg;
  logic [`LPIF_DBG_W-1:0]   rx_dbg;

  stim_t       tbl [NUM_ROWS];
  int          exp_tx_cnt = 0;
  int          exp_rx_cnt = 0;

  tb_clk_gen u_clk (
    .clk (clk_wr)
  );

  // PHY lanes looped straight back
  lpif_link_top DUT (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .ustrm                      (ustrm),
    .dstrm                      (dstrm),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy0                    (tx_phy0),
    .rx_phy1                    (tx_phy1),
    .tx_upstream_debug_status   (tx_dbg),
    .rx_downstream_debug_status (rx_dbg)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
               $time, name, exp_val, act_val);
      $display("Simulation failed");
      $fatal(1, "stopped on value check");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "stopped on timeout");
  endtask

  // dvalid and crc_valid follow valid
  task automatic set_row(input int idx, input logic [3:0] state, input logic [1:0] protid,
                         input logic [31:0] data, input logic [7:0] crc,
                         input logic valid, input logic stb, input logic [1:0] mrk);
    tbl[idx].word.state     = state;
    tbl[idx].word.protid    = protid;
    tbl[idx].word.data      = data;
    tbl[idx].word.dvalid    = valid;
    tbl[idx].word.crc       = crc;
    tbl[idx].word.crc_valid = valid;
    tbl[idx].word.valid     = valid;
    tbl[idx].stb            = stb;
    tbl[idx].mrk            = mrk;
  endtask

  task automatic build_table();
    set_row(0, 4'h1, 2'd0, $urandom(), 8'($urandom()), 1'b1, 1'b1, 2'b10);
    // All ones, then all zero with only valid
    set_row(1, 4'hF, 2'd3, 32'hFFFF_FFFF, 8'hFF, 1'b1, 1'b1, 2'b11);
    set_row(2, 4'h2, 2'd1, $urandom(), 8'($urandom()), 1'b0, 1'b1, 2'b01);
    set_row(3, 4'h0, 2'd0, 32'h0, 8'h00, 1'b1, 1'b1, 2'b00);
    set_row(4, 4'h8, 2'd2, 32'h8000_0001, 8'h80, 1'b1, 1'b1, 2'b10);
    set_row(5, 4'($urandom()), 2'($urandom()), $urandom(), 8'($urandom()),
            1'b1, 1'b1, 2'b11);
    set_row(6, 4'h3, 2'd1, $urandom(), 8'($urandom()), 1'b0, 1'b1, 2'b10);
    // Strobe off, these never reach dstrm
    set_row(7, 4'h5, 2'd2, $urandom(), 8'($urandom()), 1'b1, 1'b0, 2'b00);
    set_row(8, 4'h6, 2'd3, $urandom(), 8'($urandom()), 1'b1, 1'b0, 2'b00);
    set_row(9, 4'h7, 2'd0, $urandom(), 8'($urandom()), 1'b0, 1'b0, 2'b00);
    set_row(10, 4'hA, 2'd1, $urandom(), 8'($urandom()), 1'b1, 1'b1, 2'b10);
    set_row(11, 4'hC, 2'd3, 32'h0, 8'hFF, 1'b1, 1'b1, 2'b01);
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    int         i;
    int         cycles;
    stim_t      r;
    lpif_chan_t exp_word;

    void'($urandom(77));
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = 16'd3;
    delay_y_value  = 16'd5;
    tx_mrk_userbit = 2'b10;
    tx_stb_userbit = 1'b1;
    ustrm          = '0;
    build_table();
    repeat (8) @(posedge clk_wr);
    @(negedge clk_wr);
    arst_n = 1'b1;

    // Idle with valid words, nothing may leave or arrive
    for (i = 0; i < 6; i++) begin
      check_value("tx_phy0", '0, tx_phy0);
      check_value("tx_phy1", '0, tx_phy1);
      check_value("dstrm", '0, dstrm);
      check_value("rx_downstream_debug_status", 0, rx_dbg);
      ustrm       = '0;
      ustrm.state = 4'(i);
      ustrm.data  = $urandom();
      ustrm.crc   = 8'($urandom());
      ustrm.valid = 1'b1;
      exp_tx_cnt++;
      @(negedge clk_wr);
    end
    ustrm     = '0;
    tx_online = 1'b1;
    rx_online = 1'b1;

    // Markers show up after delay_y samples plus the PHY register
    cycles = 0;
    do begin
      @(negedge clk_wr);
      cycles++;
      if (cycles > TIMEOUT_CYC) report_timeout("tx PHY marker bits never rose");
    end while ({tx_phy1.marker, tx_phy0.marker} == 2'b00);
    check_value("marker_delay_cycles", delay_y_value + 1, cycles);
    check_value("tx_phy_marker", tx_mrk_userbit, {tx_phy1.marker, tx_phy0.marker});

    cycles = 0;
    while (!DUT.u_auto_sync.rx_online_delay) begin
      @(negedge clk_wr);
      cycles++;
      if (cycles > TIMEOUT_CYC) report_timeout("rx_online_delay never rose");
    end

    // Table, PHY seen 2 cycles later, dstrm 4 cycles later
    for (i = 0; i < NUM_ROWS + 4; i++) begin
      if (i >= 2 && i < NUM_ROWS + 2) begin
        r = tbl[i-2];
        check_value("tx_phy0", {r.mrk[0], r.stb, r.word[37:0]}, tx_phy0);
        check_value("tx_phy1", {r.mrk[1], r.stb, 27'd0, r.word[48:38]}, tx_phy1);
      end
      if (i >= 4) begin
        r        = tbl[i-4];
        exp_word = r.stb ? r.word : '0;
        if (exp_word.valid) exp_rx_cnt++;
        check_value("dstrm", exp_word, dstrm);
        check_value("rx_downstream_debug_status", exp_rx_cnt, rx_dbg);
      end
      if (i < NUM_ROWS) begin
        ustrm          = tbl[i].word;
        tx_stb_userbit = tbl[i].stb;
        tx_mrk_userbit = tbl[i].mrk;
        if (tbl[i].word.valid) exp_tx_cnt++;
      end else begin
        ustrm = '0;
      end
      @(negedge clk_wr);
    end

    check_value("tx_upstream_debug_status", exp_tx_cnt, tx_dbg);
    check_value("rx_downstream_debug_status", exp_rx_cnt, rx_dbg);
    if (DUT.u_phy_concat.u_sva.assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/lpif_link_pkg.sv
source/lpif_auto_sync.sv
source/lpif_flit_map.sv
source/lpif_phy_concat.sv
source/lpif_link_top.sv
verif/tb_clk_gen.sv
verif/lpif_link_sva.sv
verif/tb_lpif_link.sv
